/* axi_mem_credit_path.f */
design/axi_mem_pkg.sv
design/req_fifo2.sv
design/rsp_buffer.sv
design/rsp_credit_gate.sv
design/mem_responder.sv
design/axi_mem_credit_path.sv
verification/axi_mem_credit_path_tb.sv

/* design/axi_mem_credit_path.sv */
/*
 * Credit-protected memory path.
 * Credit gate in front of the memory device, with response buffers that
 * absorb the device's unthrottled responses.
 */
module axi_mem_credit_path
(
    input  logic              clk,
    input  logic              reset_n,
    input  axi_mem_pkg::aw_t  m_aw,
    input  logic              m_awvalid,
    output logic              m_awready,
    input  axi_mem_pkg::w_t   m_w,
    input  logic              m_wvalid,
    output logic              m_wready,
    input  axi_mem_pkg::ar_t  m_ar,
    input  logic              m_arvalid,
    output logic              m_arready,
    output axi_mem_pkg::b_t   m_b,
    output logic              m_bvalid,
    input  logic              m_bready,
    output axi_mem_pkg::r_t   m_r,
    output logic              m_rvalid,
    input  logic              m_rready
);

    // Gate to device
    axi_mem_pkg::aw_t s_aw;
    logic             s_awvalid;
    logic             s_awready;
    axi_mem_pkg::w_t  s_w;
    logic             s_wvalid;
    logic             s_wready;
    axi_mem_pkg::ar_t s_ar;
    logic             s_arvalid;
    logic             s_arready;

    // Device to buffers
    logic             b_push;
    axi_mem_pkg::b_t  b_push_data;
    logic             r_push;
    axi_mem_pkg::r_t  r_push_data;

    // Buffers to gate
    axi_mem_pkg::b_t  bb_data;
    logic             bb_valid;
    logic             bb_ready;
    axi_mem_pkg::r_t  rb_data;
    logic             rb_valid;
    logic             rb_ready;

    rsp_credit_gate gate0
    (
        .clk(clk), .reset_n(reset_n),
        .m_aw(m_aw), .m_awvalid(m_awvalid), .m_awready(m_awready),
        .m_w(m_w), .m_wvalid(m_wvalid), .m_wready(m_wready),
        .m_ar(m_ar), .m_arvalid(m_arvalid), .m_arready(m_arready),
        .m_b(m_b), .m_bvalid(m_bvalid), .m_bready(m_bready),
        .m_r(m_r), .m_rvalid(m_rvalid), .m_rready(m_rready),
        .s_aw(s_aw), .s_awvalid(s_awvalid), .s_awready(s_awready),
        .s_w(s_w), .s_wvalid(s_wvalid), .s_wready(s_wready),
        .s_ar(s_ar), .s_arvalid(s_arvalid), .s_arready(s_arready),
        .bb_data(bb_data), .bb_valid(bb_valid), .bb_ready(bb_ready),
        .rb_data(rb_data), .rb_valid(rb_valid), .rb_ready(rb_ready)
    );

    mem_responder mem0
    (
        .clk(clk), .reset_n(reset_n),
        .s_aw(s_aw), .s_awvalid(s_awvalid), .s_awready(s_awready),
        .s_w(s_w), .s_wvalid(s_wvalid), .s_wready(s_wready),
        .s_ar(s_ar), .s_arvalid(s_arvalid), .s_arready(s_arready),
        .b_push(b_push), .b_push_data(b_push_data),
        .r_push(r_push), .r_push_data(r_push_data)
    );

    // Each buffer is exactly as deep as its credit pool
    rsp_buffer #(
        .DEPTH(axi_mem_pkg::NUM_WRITE_CREDITS),
        .WIDTH($bits(axi_mem_pkg::b_t))
    ) b_buf
    (
        .clk(clk), .reset_n(reset_n),
        .push(b_push), .push_data(b_push_data),
        .out_data(bb_data), .out_valid(bb_valid), .out_ready(bb_ready)
    );

    rsp_buffer #(
        .DEPTH(axi_mem_pkg::NUM_READ_CREDITS),
        .WIDTH($bits(axi_mem_pkg::r_t))
    ) r_buf
    (
        .clk(clk), .reset_n(reset_n),
        .push(r_push), .push_data(r_push_data),
        .out_data(rb_data), .out_valid(rb_valid), .out_ready(rb_ready)
    );

endmodule

/* design/axi_mem_pkg.sv */
/*
 * AXI memory credit path definitions.
 * Widths, channel payload structs, credit counter types and sizing constants.
 */
package axi_mem_pkg;

    // Memory geometry and burst limits
    localparam int MEM_WORDS = 64;
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);
    localparam int MAX_RD_PER_REQ = 4;

    // Credit pools, each sized to its response buffer
    localparam int NUM_WRITE_CREDITS = 8;
    localparam int NUM_READ_CREDITS = 16;

    // Response codes
    localparam logic [1:0] RESP_OKAY = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    typedef logic [7:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0] strb_t;
    typedef logic [1:0] len_t;
    typedef logic [1:0] resp_t;

    // Counters just wide enough to hold the full credit count
    typedef logic [$clog2(NUM_WRITE_CREDITS + 1) - 1:0] wr_credit_t;
    typedef logic [$clog2(NUM_READ_CREDITS + 1) - 1:0] rd_credit_t;

    typedef struct packed {
        addr_t addr;
    } aw_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } w_t;

    typedef struct packed {
        addr_t addr;
        len_t len;
    } ar_t;

    typedef struct packed {
        resp_t resp;
    } b_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
        logic last;
    } r_t;

endpackage

/* design/mem_responder.sv */
/*
 * Simple word-addressed memory device.
 * Executes single-beat writes and read bursts, and pushes every response
 * out with no flow control.
 */
module mem_responder
(
    input  logic              clk,
    input  logic              reset_n,
    input  axi_mem_pkg::aw_t  s_aw,
    input  logic              s_awvalid,
    output logic              s_awready,
    input  axi_mem_pkg::w_t   s_w,
    input  logic              s_wvalid,
    output logic              s_wready,
    input  axi_mem_pkg::ar_t  s_ar,
    input  logic              s_arvalid,
    output logic              s_arready,
    output logic              b_push,
    output axi_mem_pkg::b_t   b_push_data,
    output logic              r_push,
    output axi_mem_pkg::r_t   r_push_data
);

    typedef enum logic {
        RD_IDLE,
        RD_BURST
    } rd_state_t;

    axi_mem_pkg::data_t  mem [axi_mem_pkg::MEM_WORDS];
    rd_state_t           rd_state;
    axi_mem_pkg::addr_t  cur_addr;
    axi_mem_pkg::addr_t  beat_addr;
    axi_mem_pkg::len_t   beat_cnt;
    axi_mem_pkg::len_t   burst_len;
    logic                wr_go;
    logic                rd_go;
    logic                wr_in_range;
    logic                rd_in_range;
    logic                beat_last;

    // Address and data are taken together, so both readies rise as one
    assign wr_go = s_awvalid && s_wvalid;
    assign s_awready = wr_go;
    assign s_wready = wr_go;
    assign wr_in_range = (s_aw.addr < axi_mem_pkg::addr_t'(axi_mem_pkg::MEM_WORDS));

    // A new burst is only taken between bursts
    assign s_arready = (rd_state == RD_IDLE);
    assign rd_go = s_arvalid && s_arready;

    // Beat 0 comes straight from the request, later beats from the counter
    assign beat_addr = (rd_state == RD_IDLE) ? s_ar.addr : cur_addr;
    assign beat_last = (rd_state == RD_IDLE) ? (s_ar.len == '0) : (beat_cnt == burst_len);
    assign rd_in_range = (beat_addr < axi_mem_pkg::addr_t'(axi_mem_pkg::MEM_WORDS));

    // Strobed byte merge; out-of-range writes leave the array alone
    always_ff @(posedge clk)
    begin
        if (wr_go && wr_in_range)
        begin
            for (int i = 0; i < $bits(axi_mem_pkg::strb_t); i++)
            begin
                if (s_w.strb[i])
                    mem[s_aw.addr[axi_mem_pkg::MEM_IDX_W-1:0]][i*8 +: 8] <= s_w.data[i*8 +: 8];
            end
        end
    end

    // Response payloads, valid only when the matching push is high
    always_ff @(posedge clk)
    begin
        b_push_data.resp <= wr_in_range ? axi_mem_pkg::RESP_OKAY : axi_mem_pkg::RESP_SLVERR;
        if (rd_in_range)
        begin
            r_push_data.data <= mem[beat_addr[axi_mem_pkg::MEM_IDX_W-1:0]];
            r_push_data.resp <= axi_mem_pkg::RESP_OKAY;
        end
        else
        begin
            r_push_data.data <= '0;
            r_push_data.resp <= axi_mem_pkg::RESP_SLVERR;
        end
        r_push_data.last <= beat_last;
    end

    // Burst sequencing; the address wraps naturally within addr_t
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_state <= RD_IDLE;
            b_push <= 1'b0;
            r_push <= 1'b0;
        end
        else
        begin
            b_push <= wr_go;
            r_push <= rd_go || (rd_state == RD_BURST);
            case (rd_state)
                RD_IDLE:
                begin
                    if (rd_go && !beat_last)
                        rd_state <= RD_BURST;
                end
                RD_BURST:
                begin
                    if (beat_last)
                        rd_state <= RD_IDLE;
                end
                default:
                    rd_state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        cur_addr <= beat_addr + 1'b1;
        if (rd_state == RD_IDLE)
        begin
            beat_cnt <= 2'd1;
            burst_len <= s_ar.len;
        end
        else
        begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

endmodule

/* design/req_fifo2.sv */
/*
 * Two-entry request FIFO with valid/ready on both sides.
 * Enqueue and dequeue may happen in the same cycle.
 */
module req_fifo2
#(
    parameter int WIDTH = 8
)
(
    input  logic             clk,
    input  logic             reset_n,
    input  logic [WIDTH-1:0] enq_data,
    input  logic             enq_valid,
    output logic             enq_ready,
    output logic [WIDTH-1:0] first,
    output logic             deq_valid,
    input  logic             deq_ready
);

    logic [WIDTH-1:0] entries [2];
    logic             wr_ptr;
    logic             rd_ptr;
    logic [1:0]       count;
    logic             do_enq;
    logic             do_deq;

    // Only a completely full FIFO pushes back on the producer
    assign enq_ready = (count != 2'd2);
    assign deq_valid = (count != 2'd0);
    assign first = entries[rd_ptr];

    assign do_enq = enq_valid && enq_ready;
    assign do_deq = deq_valid && deq_ready;

    // Payload storage carries no reset
    always_ff @(posedge clk)
    begin
        if (do_enq)
        begin
            entries[wr_ptr] <= enq_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count <= 2'd0;
        end
        else
        begin
            if (do_enq)
                wr_ptr <= ~wr_ptr;
            if (do_deq)
                rd_ptr <= ~rd_ptr;
            // A simultaneous enqueue and dequeue leaves the count unchanged
            if (do_enq && !do_deq)
                count <= count + 2'd1;
            else if (!do_enq && do_deq)
                count <= count - 2'd1;
        end
    end

endmodule

/* design/rsp_buffer.sv */
/*
 * Response buffer for a device without flow control.
 * Pushes are always taken and the contents drain over valid/ready.
 */
module rsp_buffer
#(
    parameter int DEPTH = 8,
    parameter int WIDTH = 8
)
(
    input  logic             clk,
    input  logic             reset_n,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    output logic [WIDTH-1:0] out_data,
    output logic             out_valid,
    input  logic             out_ready
);

    logic [WIDTH-1:0]             storage [DEPTH];
    logic [$clog2(DEPTH)-1:0]     wr_ptr;
    logic [$clog2(DEPTH)-1:0]     rd_ptr;
    logic [$clog2(DEPTH + 1)-1:0] count;
    logic                         pop;

    assign out_valid = (count != '0);
    assign out_data = storage[rd_ptr];
    assign pop = out_valid && out_ready;

    // Room for every push is guaranteed by the credit gate upstream
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            storage[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            // Pointers wrap explicitly so DEPTH need not be a power of two
            if (push)
            begin
                if (wr_ptr == ($clog2(DEPTH))'(DEPTH - 1))
                    wr_ptr <= '0;
                else
                    wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                if (rd_ptr == ($clog2(DEPTH))'(DEPTH - 1))
                    rd_ptr <= '0;
                else
                    rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop)
                count <= count + 1'b1;
            else if (!push && pop)
                count <= count - 1'b1;
        end
    end

endmodule

/* design/rsp_credit_gate.sv */
/*
 * Response credit gate.
 * Holds queued write and read addresses until the response buffers are
 * certain to have room, and restores credits as responses drain.
 */
module rsp_credit_gate
(
    input  logic              clk,
    input  logic              reset_n,

    input  axi_mem_pkg::aw_t  m_aw,
    input  logic              m_awvalid,
    output logic              m_awready,
    input  axi_mem_pkg::w_t   m_w,
    input  logic              m_wvalid,
    output logic              m_wready,
    input  axi_mem_pkg::ar_t  m_ar,
    input  logic              m_arvalid,
    output logic              m_arready,
    output axi_mem_pkg::b_t   m_b,
    output logic              m_bvalid,
    input  logic              m_bready,
    output axi_mem_pkg::r_t   m_r,
    output logic              m_rvalid,
    input  logic              m_rready,

    output axi_mem_pkg::aw_t  s_aw,
    output logic              s_awvalid,
    input  logic              s_awready,
    output axi_mem_pkg::w_t   s_w,
    output logic              s_wvalid,
    input  logic              s_wready,
    output axi_mem_pkg::ar_t  s_ar,
    output logic              s_arvalid,
    input  logic              s_arready,

    input  axi_mem_pkg::b_t   bb_data,
    input  logic              bb_valid,
    output logic              bb_ready,
    input  axi_mem_pkg::r_t   rb_data,
    input  logic              rb_valid,
    output logic              rb_ready
);

    axi_mem_pkg::wr_credit_t wr_credits;
    axi_mem_pkg::rd_credit_t rd_credits;
    axi_mem_pkg::rd_credit_t rd_charge;
    logic                    wr_req_valid;
    logic                    rd_req_valid;
    logic                    fwd_wr;
    logic                    fwd_rd;
    logic                    wr_ret;
    logic                    wr_ret_q;
    logic                    wr_ret_q2;
    logic                    rd_ret;
    logic                    rd_ret_q;
    logic                    rd_ret_q2;

    // Write data and both response channels pass through untouched
    assign s_w = m_w;
    assign s_wvalid = m_wvalid;
    assign m_wready = s_wready;

    assign m_b = bb_data;
    assign m_bvalid = bb_valid;
    assign bb_ready = m_bready;
    assign m_r = rb_data;
    assign m_rvalid = rb_valid;
    assign rb_ready = m_rready;

    req_fifo2 #(.WIDTH($bits(axi_mem_pkg::aw_t))) aw_fifo
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .enq_data  (m_aw),
        .enq_valid (m_awvalid),
        .enq_ready (m_awready),
        .first     (s_aw),
        .deq_valid (wr_req_valid),
        .deq_ready (fwd_wr)
    );

    req_fifo2 #(.WIDTH($bits(axi_mem_pkg::ar_t))) ar_fifo
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .enq_data  (m_ar),
        .enq_valid (m_arvalid),
        .enq_ready (m_arready),
        .first     (s_ar),
        .deq_valid (rd_req_valid),
        .deq_ready (fwd_rd)
    );

    // Each write produces exactly one response, so one credit suffices
    assign s_awvalid = wr_req_valid && (wr_credits != '0);
    assign fwd_wr = s_awvalid && s_awready;

    // A read is admitted on the worst-case burst, since the length field
    // is only trusted for the charge
    assign s_arvalid = rd_req_valid &&
                       (rd_credits >= axi_mem_pkg::rd_credit_t'(axi_mem_pkg::MAX_RD_PER_REQ));
    assign fwd_rd = s_arvalid && s_arready;
    assign rd_charge = axi_mem_pkg::rd_credit_t'(s_ar.len) + 1'b1;

    // Responses leaving the buffers, observed at the buffer handshake
    assign wr_ret = bb_valid && bb_ready;
    assign rd_ret = rb_valid && rb_ready;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ret_q <= 1'b0;
            wr_ret_q2 <= 1'b0;
            rd_ret_q <= 1'b0;
            rd_ret_q2 <= 1'b0;
            wr_credits <= axi_mem_pkg::wr_credit_t'(axi_mem_pkg::NUM_WRITE_CREDITS);
            rd_credits <= axi_mem_pkg::rd_credit_t'(axi_mem_pkg::NUM_READ_CREDITS);
        end
        else
        begin
            // Two register stages keep the return path off the critical path
            wr_ret_q <= wr_ret;
            wr_ret_q2 <= wr_ret_q;
            rd_ret_q <= rd_ret;
            rd_ret_q2 <= rd_ret_q;

            // A forward and a return on one edge cancel out
            if (fwd_wr && !wr_ret_q2)
                wr_credits <= wr_credits - 1'b1;
            else if (!fwd_wr && wr_ret_q2)
                wr_credits <= wr_credits + 1'b1;

            if (fwd_rd)
                rd_credits <= rd_credits + axi_mem_pkg::rd_credit_t'(rd_ret_q2) - rd_charge;
            else
                rd_credits <= rd_credits + axi_mem_pkg::rd_credit_t'(rd_ret_q2);
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the credit path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module axi_mem_credit_path_tb \
    -f axi_mem_credit_path.f -o sim_axi_mem_credit_path
./obj_dir/sim_axi_mem_credit_path | tee sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

/* verification/axi_mem_credit_path_tb.sv */
/*
 * Testbench for the credit-protected memory path.
 * Drives write and read batches under varying back-pressure and checks every
 * response against a model of the memory device.
 */
module axi_mem_credit_path_tb;

    localparam int CLK_PERIOD = 20;
    localparam int MAX_BATCH = 64;
    localparam int HOLD_CYCLES = 200;
    localparam int TOTAL_REQS = 380;
    localparam int PER_REQ_CYCLES = 40;
    localparam int MARGIN_CYCLES = 2 * HOLD_CYCLES + 200;
    localparam int BP_OPEN = 0;
    localparam int BP_HOLD = 1;
    localparam int BP_RANDOM = 2;

    logic             clk;
    logic             reset_n;
    axi_mem_pkg::aw_t m_aw;
    logic             m_awvalid;
    logic             m_awready;
    axi_mem_pkg::w_t  m_w;
    logic             m_wvalid;
    logic             m_wready;
    axi_mem_pkg::ar_t m_ar;
    logic             m_arvalid;
    logic             m_arready;
    axi_mem_pkg::b_t  m_b;
    logic             m_bvalid;
    logic             m_bready;
    axi_mem_pkg::r_t  m_r;
    logic             m_rvalid;
    logic             m_rready;

    integer             seed;
    int                 bp_mode;
    int                 value_errors;
    int                 protocol_errors;
    int                 b_seen;
    int                 r_seen;
    int                 wr_count;
    int                 rd_count;
    int                 nw;
    int                 nr;
    logic               aw_stall_seen;
    logic               ar_stall_seen;
    axi_mem_pkg::addr_t pick_addr [16];
    axi_mem_pkg::addr_t tmp_addr;

    // Pending request batch, issued in order
    axi_mem_pkg::addr_t wr_addr [MAX_BATCH];
    axi_mem_pkg::data_t wr_data [MAX_BATCH];
    axi_mem_pkg::strb_t wr_strb [MAX_BATCH];
    axi_mem_pkg::addr_t rd_addr [MAX_BATCH];
    axi_mem_pkg::len_t  rd_len [MAX_BATCH];

    // Model memory and the responses it predicts, oldest first
    axi_mem_pkg::data_t model_mem [axi_mem_pkg::MEM_WORDS];
    axi_mem_pkg::b_t    exp_b [$];
    axi_mem_pkg::r_t    exp_r [$];
    axi_mem_pkg::b_t    b_expected;
    axi_mem_pkg::r_t    r_expected;

    axi_mem_credit_path dut0
    (
        .clk(clk), .reset_n(reset_n),
        .m_aw(m_aw), .m_awvalid(m_awvalid), .m_awready(m_awready),
        .m_w(m_w), .m_wvalid(m_wvalid), .m_wready(m_wready),
        .m_ar(m_ar), .m_arvalid(m_arvalid), .m_arready(m_arready),
        .m_b(m_b), .m_bvalid(m_bvalid), .m_bready(m_bready),
        .m_r(m_r), .m_rvalid(m_rvalid), .m_rready(m_rready)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // A write merges strobed bytes in range; anything above the array is rejected
    function automatic axi_mem_pkg::resp_t model_write(input axi_mem_pkg::addr_t addr,
                                                       input axi_mem_pkg::data_t data,
                                                       input axi_mem_pkg::strb_t strb);
        if (int'(addr) < axi_mem_pkg::MEM_WORDS)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (strb[i])
                    model_mem[int'(addr)][i*8 +: 8] = data[i*8 +: 8];
            end
            return axi_mem_pkg::RESP_OKAY;
        end
        return axi_mem_pkg::RESP_SLVERR;
    endfunction

    // Out-of-range beats carry zero data and an error code
    function automatic axi_mem_pkg::r_t model_read_beat(input axi_mem_pkg::addr_t addr,
                                                        input logic last);
        axi_mem_pkg::r_t beat;
        beat.last = last;
        if (int'(addr) < axi_mem_pkg::MEM_WORDS)
        begin
            beat.data = model_mem[int'(addr)];
            beat.resp = axi_mem_pkg::RESP_OKAY;
        end
        else
        begin
            beat.data = '0;
            beat.resp = axi_mem_pkg::RESP_SLVERR;
        end
        return beat;
    endfunction

    task automatic queue_write(input axi_mem_pkg::addr_t addr, input axi_mem_pkg::data_t data,
                               input axi_mem_pkg::strb_t strb);
        axi_mem_pkg::b_t rsp;
        wr_addr[wr_count] = addr;
        wr_data[wr_count] = data;
        wr_strb[wr_count] = strb;
        wr_count++;
        rsp.resp = model_write(addr, data, strb);
        exp_b.push_back(rsp);
    endtask

    // Burst addresses wrap modulo 256, the same as the 8-bit address field
    task automatic queue_read(input axi_mem_pkg::addr_t addr, input axi_mem_pkg::len_t len);
        axi_mem_pkg::r_t beat;
        rd_addr[rd_count] = addr;
        rd_len[rd_count] = len;
        rd_count++;
        for (int i = 0; i <= int'(len); i++)
        begin
            beat = model_read_beat(axi_mem_pkg::addr_t'(int'(addr) + i), i == int'(len));
            exp_r.push_back(beat);
        end
    endtask

    // Address and data run as independent streams and pair up in order at the device
    task automatic issue_writes();
        fork
            begin
                for (int i = 0; i < wr_count; i++)
                begin
                    @(negedge clk);
                    m_aw.addr = wr_addr[i];
                    m_awvalid = 1'b1;
                    @(posedge clk);
                    while (!m_awready)
                        @(posedge clk);
                end
                @(negedge clk);
                m_awvalid = 1'b0;
            end
            begin
                for (int i = 0; i < wr_count; i++)
                begin
                    @(negedge clk);
                    m_w.data = wr_data[i];
                    m_w.strb = wr_strb[i];
                    m_wvalid = 1'b1;
                    @(posedge clk);
                    while (!m_wready)
                        @(posedge clk);
                end
                @(negedge clk);
                m_wvalid = 1'b0;
            end
        join
        wr_count = 0;
    endtask

    task automatic issue_reads();
        for (int i = 0; i < rd_count; i++)
        begin
            @(negedge clk);
            m_ar.addr = rd_addr[i];
            m_ar.len = rd_len[i];
            m_arvalid = 1'b1;
            @(posedge clk);
            while (!m_arready)
                @(posedge clk);
        end
        @(negedge clk);
        m_arvalid = 1'b0;
        rd_count = 0;
    endtask

    // A stray response would surface in the cycles after the queues empty
    task automatic drain_responses();
        while (exp_b.size() != 0 || exp_r.size() != 0)
            @(posedge clk);
        repeat (8) @(posedge clk);
    endtask

    // Response ready generation, held, open or random
    initial
    begin
        m_bready = 1'b0;
        m_rready = 1'b0;
        forever
        begin
            @(negedge clk);
            if (bp_mode == BP_HOLD)
            begin
                m_bready = 1'b0;
                m_rready = 1'b0;
            end
            else if (bp_mode == BP_RANDOM)
            begin
                m_bready = ({$random(seed)} % 4) != 0;
                m_rready = ({$random(seed)} % 4) != 0;
            end
            else
            begin
                m_bready = 1'b1;
                m_rready = 1'b1;
            end
        end
    end

    // Request ports that refuse a pending request while its responses are held back
    always @(posedge clk)
    begin
        if (m_awvalid && !m_awready && !m_bready)
            aw_stall_seen = 1'b1;
        if (m_arvalid && !m_arready && !m_rready)
            ar_stall_seen = 1'b1;
    end

    // Compare every response handshake with the oldest expected response
    always @(posedge clk)
    begin
        if (reset_n && m_bvalid && m_bready)
        begin
            assert (exp_b.size() != 0)
            else
            begin
                protocol_errors++;
                $display("A write response arrived at %0t with no write outstanding", $time);
            end
            if (exp_b.size() != 0)
            begin
                b_expected = exp_b.pop_front();
                b_seen++;
                assert (m_b == b_expected)
                else
                begin
                    value_errors++;
                    $display("error at %0t: write resp %0d, expected %0d",
                             $time, m_b.resp, b_expected.resp);
                end
            end
        end
        if (reset_n && m_rvalid && m_rready)
        begin
            assert (exp_r.size() != 0)
            else
            begin
                protocol_errors++;
                $display("A read beat arrived at %0t with no read outstanding", $time);
            end
            if (exp_r.size() != 0)
            begin
                r_expected = exp_r.pop_front();
                r_seen++;
                assert (m_r == r_expected)
                else
                begin
                    value_errors++;
                    $display("error at %0t: read beat %h/%0d/%0b, expected %h/%0d/%0b",
                             $time, m_r.data, m_r.resp, m_r.last,
                             r_expected.data, r_expected.resp, r_expected.last);
                end
            end
        end
    end

    // Bound derived from the request count and a per-request worst case
    initial
    begin
        #(CLK_PERIOD * (TOTAL_REQS * PER_REQ_CYCLES + MARGIN_CYCLES));
        $display("The run hung: responses were still outstanding when time ran out");
        $display("Something failed");
        $finish;
    end

    initial
    begin
        seed = 84969;
        bp_mode = BP_OPEN;
        value_errors = 0;
        protocol_errors = 0;
        b_seen = 0;
        r_seen = 0;
        wr_count = 0;
        rd_count = 0;
        aw_stall_seen = 1'b0;
        ar_stall_seen = 1'b0;
        reset_n = 1'b0;
        m_aw = '0;
        m_awvalid = 1'b0;
        m_w = '0;
        m_wvalid = 1'b0;
        m_ar = '0;
        m_arvalid = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        // Reset state, checked before the first active edge
        assert (!m_bvalid && !m_rvalid && m_awready && m_arready)
        else
        begin
            value_errors++;
            $display("error at %0t: reset state bvalid %0b rvalid %0b awready %0b arready %0b",
                     $time, m_bvalid, m_rvalid, m_awready, m_arready);
        end

        // Every word gets a known value first
        for (int i = 0; i < axi_mem_pkg::MEM_WORDS; i++)
        begin
            tmp_addr = axi_mem_pkg::addr_t'(i);
            queue_write(tmp_addr, {8'hc3, tmp_addr, ~tmp_addr, tmp_addr ^ 8'h5a}, 4'hf);
        end
        issue_writes();
        drain_responses();

        // Single writes with random strobes, read back one beat each
        for (int i = 0; i < 16; i++)
        begin
            pick_addr[i] = axi_mem_pkg::addr_t'({$random(seed)} % axi_mem_pkg::MEM_WORDS);
            queue_write(pick_addr[i], axi_mem_pkg::data_t'($random(seed)),
                        axi_mem_pkg::strb_t'($random(seed)));
        end
        issue_writes();
        drain_responses();
        for (int i = 0; i < 16; i++)
            queue_read(pick_addr[i], 2'd0);
        issue_reads();
        drain_responses();

        // Bursts of every length
        for (int len = 0; len < 4; len++)
        begin
            queue_read(axi_mem_pkg::addr_t'($random(seed) & 8'h3f), axi_mem_pkg::len_t'(len));
            queue_read(axi_mem_pkg::addr_t'($random(seed) & 8'h3f), axi_mem_pkg::len_t'(len));
        end
        issue_reads();
        drain_responses();

        // Out-of-range writes whose low bits alias real words
        for (int i = 0; i < 4; i++)
        begin
            pick_addr[i] = axi_mem_pkg::addr_t'(64 + {$random(seed)} % 192);
            queue_write(pick_addr[i], axi_mem_pkg::data_t'($random(seed)), 4'hf);
        end
        issue_writes();
        drain_responses();
        for (int i = 0; i < 4; i++)
            queue_read(pick_addr[i] & 8'h3f, 2'd0);
        queue_read(8'd62, 2'd3);
        queue_read(8'd254, 2'd3);
        queue_read(8'd150, 2'd1);
        issue_reads();
        drain_responses();

        // Long back-pressure on writes, then on maximum bursts
        aw_stall_seen = 1'b0;
        ar_stall_seen = 1'b0;
        bp_mode = BP_HOLD;
        for (int i = 0; i < 30; i++)
        begin
            queue_write(axi_mem_pkg::addr_t'({$random(seed)} % axi_mem_pkg::MEM_WORDS),
                        axi_mem_pkg::data_t'($random(seed)), axi_mem_pkg::strb_t'($random(seed)));
        end
        fork
            issue_writes();
            begin
                repeat (HOLD_CYCLES) @(posedge clk);
                bp_mode = BP_OPEN;
            end
        join
        drain_responses();
        bp_mode = BP_HOLD;
        for (int i = 0; i < 30; i++)
            queue_read(axi_mem_pkg::addr_t'($random(seed)), 2'd3);
        fork
            issue_reads();
            begin
                repeat (HOLD_CYCLES) @(posedge clk);
                bp_mode = BP_OPEN;
            end
        join
        drain_responses();
        assert (aw_stall_seen && ar_stall_seen)
        else
        begin
            protocol_errors++;
            $display("The request ports kept accepting while responses were held back");
        end

        // Random batches under random back-pressure
        bp_mode = BP_RANDOM;
        for (int batch = 0; batch < 8; batch++)
        begin
            nw = 1 + {$random(seed)} % 12;
            for (int i = 0; i < nw; i++)
            begin
                queue_write(axi_mem_pkg::addr_t'({$random(seed)} % 80),
                            axi_mem_pkg::data_t'($random(seed)),
                            axi_mem_pkg::strb_t'($random(seed)));
            end
            issue_writes();
            drain_responses();
            nr = 1 + {$random(seed)} % 12;
            for (int i = 0; i < nr; i++)
            begin
                queue_read(axi_mem_pkg::addr_t'({$random(seed)} % 80),
                           axi_mem_pkg::len_t'($random(seed)));
            end
            issue_reads();
            drain_responses();
        end

        $display("Checked %0d write and %0d read responses: %0d value errors, %0d protocol errors",
                 b_seen, r_seen, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule
